// File: hw/fd_cfg.svh
`ifndef FD_CFG_SVH
`define FD_CFG_SVH

// active video size.
`define FD_H_ACT        16
`define FD_V_ACT        4

// one burst is 16 beats of 8 bytes.
`define FD_BURST_BEATS  16
`define FD_FIFO_BEATS   32

// idle cycles after vs_i falls.
`define FD_CLR_CYCLES   15

// bank A start, bank B follows one frame later.
`define FD_BASE_DEFAULT 32'h2000_0000

`endif

// File: hw/fd_pkg.sv
package fd_pkg;

   typedef logic [23:0] pixel_t;  // rgb, 8 bits each.
   typedef logic [63:0] beat_t;   // two pixels, one per 32-bit lane.
   typedef logic [31:0] addr_t;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_t;

endpackage

// File: hw/axi_if.sv
`timescale 1ns/1ps

// aw, w and b channels.
interface axi_wr_if;
   logic          awvalid;
   logic          awready;
   fd_pkg::addr_t awaddr;
   logic          wvalid;
   logic          wready;
   fd_pkg::beat_t wdata;
   logic [7:0]    wstrb;
   logic          wlast;
   logic          bvalid;
   logic          bready;

   modport mst (output awvalid, awaddr, wvalid, wdata, wstrb, wlast, bready,
                input awready, wready, bvalid);
   modport slv (input awvalid, awaddr, wvalid, wdata, wstrb, wlast, bready,
                output awready, wready, bvalid);
endinterface

// ar and r channels.
interface axi_rd_if;
   logic          arvalid;
   logic          arready;
   fd_pkg::addr_t araddr;
   logic          rvalid;
   logic          rready;
   fd_pkg::beat_t rdata;
   logic          rlast;

   modport mst (output arvalid, araddr, rready,
                input arready, rvalid, rdata, rlast);
   modport slv (input arvalid, araddr, rready,
                output arready, rvalid, rdata, rlast);
endinterface

// File: hw/frame_delay_regs.sv
`timescale 1ns/1ps
`include "fd_cfg.svh"

module frame_delay_regs (
   input  logic          clk_i,
   input  logic          rst_i,
   input  logic          reg_we_i,
   input  logic [1:0]    reg_addr_i,
   input  logic [31:0]   reg_wdata_i,
   output logic [31:0]   reg_rdata_o,
   output logic          wen_o,
   output logic          ren_o,
   output fd_pkg::addr_t base_o
);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wen_o  <= 1'b0;
         ren_o  <= 1'b0;
         base_o <= `FD_BASE_DEFAULT;
      end else if (reg_we_i) begin
         case (reg_addr_i)
            2'd0: begin
               wen_o <= reg_wdata_i[0];
               ren_o <= reg_wdata_i[1];
            end
            2'd1: base_o <= reg_wdata_i;
            default: ;  // unmapped.
         endcase
      end
   end

   always_comb begin
      case (reg_addr_i)
         2'd0:    reg_rdata_o = {30'd0, ren_o, wen_o};
         2'd1:    reg_rdata_o = base_o;
         default: reg_rdata_o = 32'd0;
      endcase
   end

endmodule

// File: hw/axi_sink.sv
`timescale 1ns/1ps
`include "fd_cfg.svh"

module axi_sink (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           srst_i,
   input  logic           en_i,
   input  fd_pkg::addr_t  addr_i,
   input  logic           val_i,
   input  fd_pkg::pixel_t data_i,
   axi_wr_if.mst          wr
);

   localparam int AW = $clog2(`FD_FIFO_BEATS);
   localparam int BW = $clog2(`FD_BURST_BEATS);
   localparam logic [AW:0] BURST_FILL = (AW + 1)'(`FD_BURST_BEATS);
   localparam logic [BW-1:0] LAST_BEAT = BW'(`FD_BURST_BEATS - 1);
   localparam fd_pkg::addr_t BURST_BYTES = fd_pkg::addr_t'(`FD_BURST_BEATS * 8);

   fd_pkg::wr_state_t state;
   fd_pkg::beat_t     mem [`FD_FIFO_BEATS];
   logic [AW:0]       wr_ptr;
   logic [AW:0]       rd_ptr;
   logic [AW:0]       fill;
   logic [BW-1:0]     beat_cnt;
   fd_pkg::pixel_t    lo_pix;
   fd_pkg::addr_t     addr;
   logic              half;
   logic              push;
   logic              pop;

   assign fill = wr_ptr - rd_ptr;
   assign push = val_i & en_i & ~srst_i & half;  // second pixel completes a beat.
   assign pop  = wr.wvalid & wr.wready;

   // pixel pairing, low lane first.
   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         half <= 1'b0;
      end else if (val_i && en_i) begin
         half <= ~half;
      end
   end

   always_ff @(posedge clk_i) begin
      if (val_i && en_i && !half) lo_pix <= data_i;
      if (push) mem[wr_ptr[AW-1:0]] <= {8'h00, data_i, 8'h00, lo_pix};
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // a full burst is buffered before the address goes out.
   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         state    <= fd_pkg::WR_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            fd_pkg::WR_IDLE: if (fill >= BURST_FILL) state <= fd_pkg::WR_ADDR;
            fd_pkg::WR_ADDR: begin
               if (wr.awready) begin
                  state    <= fd_pkg::WR_DATA;
                  beat_cnt <= '0;
               end
            end
            fd_pkg::WR_DATA: begin
               if (wr.wready) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (wr.wlast) state <= fd_pkg::WR_RESP;
               end
            end
            fd_pkg::WR_RESP: if (wr.bvalid) state <= fd_pkg::WR_IDLE;
            default: state <= fd_pkg::WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         addr <= addr_i;  // bank start.
      end else if (wr.awvalid && wr.awready) begin
         addr <= addr + BURST_BYTES;
      end
   end

   assign wr.awvalid = (state == fd_pkg::WR_ADDR);
   assign wr.awaddr  = addr;
   assign wr.wvalid  = (state == fd_pkg::WR_DATA);  // data already buffered.
   assign wr.wdata   = mem[rd_ptr[AW-1:0]];
   assign wr.wstrb   = 8'hff;
   assign wr.wlast   = (beat_cnt == LAST_BEAT);
   assign wr.bready  = (state == fd_pkg::WR_RESP);

endmodule

// File: hw/axi_source.sv
`timescale 1ns/1ps
`include "fd_cfg.svh"

module axi_source (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           srst_i,
   input  logic           en_i,
   input  fd_pkg::addr_t  addr_i,
   input  logic           rdy_i,
   output fd_pkg::pixel_t data_o,
   axi_rd_if.mst          rd
);

   localparam int AW = $clog2(`FD_FIFO_BEATS);
   localparam int FRAME_BURSTS = `FD_H_ACT * `FD_V_ACT / (2 * `FD_BURST_BEATS);
   localparam int CW = $clog2(FRAME_BURSTS + 1);
   localparam logic [AW:0] MAX_FILL = (AW + 1)'(`FD_FIFO_BEATS - `FD_BURST_BEATS);
   localparam logic [CW-1:0] LAST_CNT = CW'(FRAME_BURSTS);
   localparam fd_pkg::addr_t BURST_BYTES = fd_pkg::addr_t'(`FD_BURST_BEATS * 8);

   fd_pkg::rd_state_t state;
   fd_pkg::beat_t     mem [`FD_FIFO_BEATS];
   fd_pkg::beat_t     head;
   logic [AW:0]       wr_ptr;
   logic [AW:0]       rd_ptr;
   logic [AW:0]       fill;
   logic [CW-1:0]     burst_cnt;
   fd_pkg::addr_t     addr;
   logic              half;
   logic              take;
   logic              push;
   logic              pop;

   assign fill = wr_ptr - rd_ptr;
   assign push = rd.rvalid & rd.rready;
   assign take = rdy_i & (fill != '0);
   assign pop  = take & half;  // beat done after its high pixel.

   always_ff @(posedge clk_i) begin
      if (push) mem[wr_ptr[AW-1:0]] <= rd.rdata;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         half   <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         if (take) half   <= ~half;
      end
   end

   // one burst in flight; space for it is free before ar goes out.
   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         state <= fd_pkg::RD_IDLE;
      end else begin
         case (state)
            fd_pkg::RD_IDLE: begin
               if (en_i && burst_cnt != LAST_CNT && fill <= MAX_FILL) begin
                  state <= fd_pkg::RD_ADDR;
               end
            end
            fd_pkg::RD_ADDR: if (rd.arready) state <= fd_pkg::RD_DATA;
            fd_pkg::RD_DATA: if (rd.rvalid && rd.rlast) state <= fd_pkg::RD_IDLE;
            default: state <= fd_pkg::RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || srst_i) begin
         addr      <= addr_i;
         burst_cnt <= '0;
      end else if (rd.arvalid && rd.arready) begin
         addr      <= addr + BURST_BYTES;
         burst_cnt <= burst_cnt + 1'b1;
      end
   end

   assign rd.arvalid = (state == fd_pkg::RD_ADDR);
   assign rd.araddr  = addr;
   assign rd.rready  = (state == fd_pkg::RD_DATA);

   // low lane, then high lane.
   assign head   = mem[rd_ptr[AW-1:0]];
   assign data_o = half ? head[55:32] : head[23:0];

endmodule

// File: hw/axi_delayer.sv
`timescale 1ns/1ps
`include "fd_cfg.svh"

module axi_delayer (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           wen_i,
   input  logic           ren_i,
   input  fd_pkg::addr_t  base_i,
   input  logic           vs_i,
   input  logic           de_i,
   input  fd_pkg::pixel_t data_i,
   output fd_pkg::pixel_t data_o,
   axi_wr_if.mst          wr,
   axi_rd_if.mst          rd
);

   localparam int CW = $clog2(`FD_CLR_CYCLES + 1);
   localparam fd_pkg::addr_t FRAME_BYTES = fd_pkg::addr_t'(`FD_H_ACT * `FD_V_ACT * 4);

   logic          vs_r;
   logic          bank;
   logic [CW-1:0] clr_cnt;
   logic          clear;
   fd_pkg::addr_t bank_a;
   fd_pkg::addr_t bank_b;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vs_r    <= 1'b0;
         bank    <= 1'b0;
         clr_cnt <= '0;
      end else begin
         vs_r <= vs_i;
         bank <= bank ^ (vs_i & ~vs_r);  // swap on rising vs.
         if (vs_i) clr_cnt <= CW'(`FD_CLR_CYCLES);
         else if (clr_cnt != '0) clr_cnt <= clr_cnt - 1'b1;
      end
   end

   assign clear  = vs_i | (clr_cnt != '0);
   assign bank_a = base_i;
   assign bank_b = base_i + FRAME_BYTES;

   // first vs after reset sets bank, so frame one lands in bank A.
   axi_sink i_sink (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .srst_i (clear),
      .en_i   (wen_i),
      .addr_i (bank ? bank_a : bank_b),
      .val_i  (de_i),
      .data_i (data_i),
      .wr     (wr)
   );

   axi_source i_source (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .srst_i (clear),
      .en_i   (ren_i),
      .addr_i (bank ? bank_b : bank_a),
      .rdy_i  (de_i),
      .data_o (data_o),
      .rd     (rd)
   );

endmodule

// File: hw/frame_delay_top.sv
`timescale 1ns/1ps

module frame_delay_top (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           reg_we_i,
   input  logic [1:0]     reg_addr_i,
   input  logic [31:0]    reg_wdata_i,
   output logic [31:0]    reg_rdata_o,
   input  logic           vs_i,
   input  logic           de_i,
   input  fd_pkg::pixel_t data_i,
   output fd_pkg::pixel_t data_o,
   output logic           m_axi_awvalid,
   input  logic           m_axi_awready,
   output fd_pkg::addr_t  m_axi_awaddr,
   output logic [3:0]     m_axi_awlen,
   output logic [2:0]     m_axi_awsize,
   output logic [1:0]     m_axi_awburst,
   output logic [5:0]     m_axi_awid,
   output logic           m_axi_wvalid,
   input  logic           m_axi_wready,
   output fd_pkg::beat_t  m_axi_wdata,
   output logic [7:0]     m_axi_wstrb,
   output logic           m_axi_wlast,
   output logic [5:0]     m_axi_wid,
   input  logic           m_axi_bvalid,
   output logic           m_axi_bready,
   output logic           m_axi_arvalid,
   input  logic           m_axi_arready,
   output fd_pkg::addr_t  m_axi_araddr,
   output logic [3:0]     m_axi_arlen,
   output logic [2:0]     m_axi_arsize,
   output logic [1:0]     m_axi_arburst,
   output logic [5:0]     m_axi_arid,
   input  logic           m_axi_rvalid,
   output logic           m_axi_rready,
   input  fd_pkg::beat_t  m_axi_rdata,
   input  logic           m_axi_rlast
);

   logic          wen;
   logic          ren;
   fd_pkg::addr_t base;

   axi_wr_if wr_bus ();
   axi_rd_if rd_bus ();

   frame_delay_regs i_regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .reg_we_i    (reg_we_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_rdata_o (reg_rdata_o),
      .wen_o       (wen),
      .ren_o       (ren),
      .base_o      (base)
   );

   axi_delayer i_delayer (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .wen_i  (wen),
      .ren_i  (ren),
      .base_i (base),
      .vs_i   (vs_i),
      .de_i   (de_i),
      .data_i (data_i),
      .data_o (data_o),
      .wr     (wr_bus.mst),
      .rd     (rd_bus.mst)
   );

   // 16 beats, 8 bytes, incr.
   assign m_axi_awlen   = 4'd15;
   assign m_axi_awsize  = 3'd3;
   assign m_axi_awburst = 2'b01;
   assign m_axi_awid    = 6'd0;
   assign m_axi_wid     = 6'd0;
   assign m_axi_arlen   = 4'd15;
   assign m_axi_arsize  = 3'd3;
   assign m_axi_arburst = 2'b01;
   assign m_axi_arid    = 6'd0;

   assign m_axi_awvalid  = wr_bus.awvalid;
   assign wr_bus.awready = m_axi_awready;
   assign m_axi_awaddr   = wr_bus.awaddr;
   assign m_axi_wvalid   = wr_bus.wvalid;
   assign wr_bus.wready  = m_axi_wready;
   assign m_axi_wdata    = wr_bus.wdata;
   assign m_axi_wstrb    = wr_bus.wstrb;
   assign m_axi_wlast    = wr_bus.wlast;
   assign wr_bus.bvalid  = m_axi_bvalid;
   assign m_axi_bready   = wr_bus.bready;

   assign m_axi_arvalid  = rd_bus.arvalid;
   assign rd_bus.arready = m_axi_arready;
   assign m_axi_araddr   = rd_bus.araddr;
   assign rd_bus.rvalid  = m_axi_rvalid;
   assign m_axi_rready   = rd_bus.rready;
   assign rd_bus.rdata   = m_axi_rdata;
   assign rd_bus.rlast   = m_axi_rlast;

endmodule

// File: tb/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
   input  logic          clk_i,
   input  logic          rst_i,
   input  logic [3:0]    stall_i,  // aw, w, ar, r.
   input  logic          awvalid_i,
   output logic          awready_o,
   input  fd_pkg::addr_t awaddr_i,
   input  logic          wvalid_i,
   output logic          wready_o,
   input  fd_pkg::beat_t wdata_i,
   input  logic          wlast_i,
   output logic          bvalid_o,
   input  logic          bready_i,
   input  logic          arvalid_i,
   output logic          arready_o,
   input  fd_pkg::addr_t araddr_i,
   output logic          rvalid_o,
   input  logic          rready_i,
   output fd_pkg::beat_t rdata_o,
   output logic          rlast_o
);

   fd_pkg::beat_t store [fd_pkg::addr_t];  // keyed by beat address.
   fd_pkg::addr_t wptr;
   fd_pkg::addr_t rptr;
   logic          w_busy;
   logic          r_busy;
   logic [3:0]    r_cnt;

   assign awready_o = ~w_busy & ~bvalid_o & ~stall_i[0];
   assign wready_o  = w_busy & ~stall_i[1];
   assign arready_o = ~r_busy & ~stall_i[2];

   always @(posedge clk_i) begin
      if (rst_i) begin
         w_busy   <= 1'b0;
         bvalid_o <= 1'b0;
         r_busy   <= 1'b0;
         rvalid_o <= 1'b0;
         rlast_o  <= 1'b0;
         rdata_o  <= '0;
         r_cnt    <= '0;
         wptr     <= '0;
         rptr     <= '0;
      end else begin
         if (awvalid_i && awready_o) begin
            wptr   <= awaddr_i;
            w_busy <= 1'b1;
         end
         if (wvalid_i && wready_o) begin
            store[wptr] = wdata_i;
            wptr <= wptr + 32'd8;
            if (wlast_i) begin
               w_busy   <= 1'b0;
               bvalid_o <= 1'b1;
            end
         end
         if (bvalid_o && bready_i) bvalid_o <= 1'b0;

         // one beat at a time, a stall only delays the next one.
         if (arvalid_i && arready_o) begin
            rptr   <= araddr_i;
            r_cnt  <= '0;
            r_busy <= 1'b1;
         end else if (r_busy) begin
            if (rvalid_o && rready_i) begin
               rvalid_o <= 1'b0;
               rptr     <= rptr + 32'd8;
               r_cnt    <= r_cnt + 4'd1;
               if (r_cnt == 4'd15) r_busy <= 1'b0;
            end else if (!rvalid_o && !stall_i[3]) begin
               rvalid_o <= 1'b1;
               rdata_o  <= store.exists(rptr) ? store[rptr] : '0;  // unwritten reads zero.
               rlast_o  <= (r_cnt == 4'd15);
            end
         end
      end
   end

endmodule

// File: tb/tb_frame_delay.sv
`timescale 1ns/1ps
`include "fd_cfg.svh"

module tb_frame_delay;

   localparam int FRAME_PIX    = `FD_H_ACT * `FD_V_ACT;
   localparam int FRAME_BEATS  = FRAME_PIX / 2;
   localparam int FRAME_BURSTS = FRAME_BEATS / `FD_BURST_BEATS;
   localparam int FRAME_BYTES  = FRAME_PIX * 4;
   localparam int NUM_FRAMES   = 10;
   localparam int BASE_FRAME   = 6;  // new base programmed here.
   localparam int SKIP_FRAME   = 9;  // frame with wen cleared.
   localparam fd_pkg::addr_t NEW_BASE = 32'h3000_0000;
   localparam int FRAME_CYCLES = 4 + 200 + `FD_V_ACT * (2 * `FD_H_ACT + 60) + 100;
   localparam int TIMEOUT      = NUM_FRAMES * FRAME_CYCLES * 4;

   logic           clk_i;
   logic           rst_i;
   logic           reg_we_i;
   logic [1:0]     reg_addr_i;
   logic [31:0]    reg_wdata_i;
   logic [31:0]    reg_rdata_o;
   logic           vs_i;
   logic           de_i;
   fd_pkg::pixel_t data_i;
   fd_pkg::pixel_t data_o;
   logic           m_axi_awvalid;
   logic           m_axi_awready;
   fd_pkg::addr_t  m_axi_awaddr;
   logic [3:0]     m_axi_awlen;
   logic [2:0]     m_axi_awsize;
   logic [1:0]     m_axi_awburst;
   logic [5:0]     m_axi_awid;
   logic           m_axi_wvalid;
   logic           m_axi_wready;
   fd_pkg::beat_t  m_axi_wdata;
   logic [7:0]     m_axi_wstrb;
   logic           m_axi_wlast;
   logic [5:0]     m_axi_wid;
   logic           m_axi_bvalid;
   logic           m_axi_bready;
   logic           m_axi_arvalid;
   logic           m_axi_arready;
   fd_pkg::addr_t  m_axi_araddr;
   logic [3:0]     m_axi_arlen;
   logic [2:0]     m_axi_arsize;
   logic [1:0]     m_axi_arburst;
   logic [5:0]     m_axi_arid;
   logic           m_axi_rvalid;
   logic           m_axi_rready;
   fd_pkg::beat_t  m_axi_rdata;
   logic           m_axi_rlast;

   logic [3:0]     mem_stall;
   logic [31:0]    rng;
   int             cycle_cnt = 0;

   // bus monitor state.
   fd_pkg::addr_t  aw_q [$];
   fd_pkg::addr_t  ar_q [$];
   int             aw_cnt = 0;
   int             wbeat_cnt = 0;
   int             burst_beat = 0;
   int             last_cnt = 0;
   int             b_cnt = 0;

   // reference model, pixels keyed by byte address.
   fd_pkg::pixel_t model_mem [fd_pkg::addr_t];
   fd_pkg::addr_t  model_base;
   logic           model_wen;
   int             frames_written;

   frame_delay_top uut (.*);

   tb_axi_mem axi_mem (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .stall_i   (mem_stall),
      .awvalid_i (m_axi_awvalid),
      .awready_o (m_axi_awready),
      .awaddr_i  (m_axi_awaddr),
      .wvalid_i  (m_axi_wvalid),
      .wready_o  (m_axi_wready),
      .wdata_i   (m_axi_wdata),
      .wlast_i   (m_axi_wlast),
      .bvalid_o  (m_axi_bvalid),
      .bready_i  (m_axi_bready),
      .arvalid_i (m_axi_arvalid),
      .arready_o (m_axi_arready),
      .araddr_i  (m_axi_araddr),
      .rvalid_o  (m_axi_rvalid),
      .rready_i  (m_axi_rready),
      .rdata_o   (m_axi_rdata),
      .rlast_o   (m_axi_rlast)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic fd_pkg::pixel_t model_read(input fd_pkg::addr_t a);
      if (model_mem.exists(a)) return model_mem[a];
      return '0;  // memory starts at zero.
   endfunction

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         fail_stop($sformatf("FAIL t=%0t %s expected %0h got %0h",
                             $time, name, expected, actual));
      end
   endtask

   // next cycle, with fresh ready stalls for the memory.
   task automatic tick();
      logic [31:0] r;
      @(posedge clk_i);
      #1;
      r = next_rand();
      mem_stall = {r[7:6] == 2'd0, r[5:4] == 2'd0, r[3:2] == 2'd0, r[1:0] == 2'd0};
   endtask

   task automatic read_check(input logic [1:0] addr, input logic [31:0] expected);
      tick();
      reg_addr_i = addr;
      @(negedge clk_i);
      check_value($sformatf("reg_rdata_o[%0d]", addr), expected, reg_rdata_o);
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
      tick();
      reg_we_i    = 1'b1;
      reg_addr_i  = addr;
      reg_wdata_i = data;
      tick();
      reg_we_i = 1'b0;
      @(negedge clk_i);
      check_value($sformatf("reg_rdata_o[%0d]", addr), data, reg_rdata_o);  // readback.
   endtask

   task automatic run_frame(input int idx);
      fd_pkg::addr_t  wbank;
      fd_pkg::addr_t  rbank;
      fd_pkg::addr_t  pa;
      fd_pkg::pixel_t pix;
      logic [31:0]    r;
      int             b_start;
      int             i;
      model_wen = (idx != SKIP_FRAME);
      // odd frames write bank A and read bank B.
      wbank = model_base + ((idx % 2 == 1) ? 32'd0 : fd_pkg::addr_t'(FRAME_BYTES));
      rbank = model_base + ((idx % 2 == 1) ? fd_pkg::addr_t'(FRAME_BYTES) : 32'd0);
      aw_q.delete();
      ar_q.delete();
      b_start = b_cnt;

      tick();
      vs_i = 1'b1;
      de_i = 1'b0;
      write_reg(2'd0, {30'd0, 1'b1, model_wen});  // ctrl changes while clear holds.
      tick();
      tick();
      vs_i = 1'b0;
      repeat (199) tick();

      for (i = 0; i < FRAME_PIX; i++) begin
         r = next_rand();
         if (r[0]) begin
            tick();
            de_i = 1'b0;
         end
         pix = r[31:8];
         tick();
         de_i   = 1'b1;
         data_i = pix;
         @(negedge clk_i);
         check_value("data_o", model_read(rbank + fd_pkg::addr_t'(4 * i)), data_o);
         if (model_wen) model_mem[wbank + fd_pkg::addr_t'(4 * i)] = pix;
         if (i % `FD_H_ACT == `FD_H_ACT - 1) begin
            tick();
            de_i = 1'b0;
            repeat (59) tick();  // line blanking.
         end
      end

      if (idx == BASE_FRAME) begin
         write_reg(2'd1, NEW_BASE);
         model_base = NEW_BASE;
      end
      if (model_wen) begin
         while (b_cnt - b_start < FRAME_BURSTS) tick();  // last burst done before next vs.
         frames_written++;
      end
      check_value("awaddr count", model_wen ? FRAME_BURSTS : 0, aw_q.size());
      for (i = 0; i < aw_q.size(); i++) begin
         pa = wbank + fd_pkg::addr_t'(`FD_BURST_BEATS * 8 * i);
         check_value("m_axi_awaddr", pa, aw_q[i]);
      end
      check_value("araddr count", FRAME_BURSTS, ar_q.size());
      for (i = 0; i < ar_q.size(); i++) begin
         pa = rbank + fd_pkg::addr_t'(`FD_BURST_BEATS * 8 * i);
         check_value("m_axi_araddr", pa, ar_q[i]);
      end
   endtask

   always @(negedge clk_i) begin
      if (!rst_i) begin
         if (m_axi_awvalid && m_axi_awready) begin
            aw_q.push_back(m_axi_awaddr);
            aw_cnt++;
            check_value("m_axi_awlen", 4'd15, m_axi_awlen);
            check_value("m_axi_awsize", 3'd3, m_axi_awsize);
            check_value("m_axi_awburst", 2'b01, m_axi_awburst);
            check_value("m_axi_awid", 6'd0, m_axi_awid);
         end
         if (m_axi_wvalid && m_axi_wready) begin
            wbeat_cnt++;
            check_value("m_axi_wstrb", 8'hff, m_axi_wstrb);
            check_value("m_axi_wid", 6'd0, m_axi_wid);
            check_value("m_axi_wlast", burst_beat == `FD_BURST_BEATS - 1, m_axi_wlast);
            if (m_axi_wlast) begin
               last_cnt++;
               burst_beat = 0;
            end else begin
               burst_beat++;
            end
         end
         if (m_axi_bvalid && m_axi_bready) b_cnt++;
         if (m_axi_arvalid && m_axi_arready) begin
            ar_q.push_back(m_axi_araddr);
            check_value("m_axi_arlen", 4'd15, m_axi_arlen);
            check_value("m_axi_arsize", 3'd3, m_axi_arsize);
            check_value("m_axi_arburst", 2'b01, m_axi_arburst);
            check_value("m_axi_arid", 6'd0, m_axi_arid);
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT) begin
         fail_stop($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT));
      end
   end

   initial begin
      rng            = 32'hcc5a0e5a;
      rst_i          = 1'b1;
      reg_we_i       = 1'b0;
      reg_addr_i     = 2'd0;
      reg_wdata_i    = 32'd0;
      vs_i           = 1'b0;
      de_i           = 1'b0;
      data_i         = '0;
      mem_stall      = 4'd0;
      model_base     = `FD_BASE_DEFAULT;
      model_wen      = 1'b0;
      frames_written = 0;
      repeat (8) tick();
      rst_i = 1'b0;

      read_check(2'd0, 32'd0);
      read_check(2'd1, `FD_BASE_DEFAULT);
      write_reg(2'd0, 32'd1);
      write_reg(2'd0, 32'd0);
      write_reg(2'd1, 32'h1234_5678);
      write_reg(2'd1, `FD_BASE_DEFAULT);

      for (int f = 1; f <= NUM_FRAMES; f++) begin
         run_frame(f);
      end

      check_value("write beats", frames_written * FRAME_BEATS, wbeat_cnt);
      check_value("bursts with wlast", aw_cnt, last_cnt);
      check_value("write responses", aw_cnt, b_cnt);
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: sources.f
+incdir+hw
hw/fd_pkg.sv
hw/axi_if.sv
hw/frame_delay_regs.sv
hw/axi_sink.sv
hw/axi_source.sv
hw/axi_delayer.sv
hw/frame_delay_top.sv
tb/tb_axi_mem.sv
tb/tb_frame_delay.sv

// File: run.sh
#!/bin/sh
# Build and run the frame delay testbench with Verilator.
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing -Wno-fatal --top-module tb_frame_delay \
   -f sources.f --Mdir build/obj -o sim_tb

./build/obj/sim_tb | tee build/sim.log

if grep -q "^=== PASS ===$" build/sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
